// ==== files.f ====
+incdir+rtl
rtl/io_map_pkg.sv
rtl/io_regs_pkg.sv
rtl/io_reg_if.sv
rtl/io_decoder.sv
rtl/irq_controller.sv
rtl/io_timer.sv
rtl/io_gpio.sv
rtl/io_system.sv
testbench/io_tb_clock.sv
testbench/io_system_checker.sv
testbench/io_system_tb.sv

// ==== rtl/io_decoder.sv ====
`timescale 1ns/1ps
`include "io_macros.svh"

module io_decoder
(
	input  logic              clk,
	input  logic              rst_n,
	input  io_map_pkg::addr_t rd_addr,
	input  io_map_pkg::addr_t wr_addr,
	input  io_map_pkg::data_t wr_data,
	input  io_map_pkg::lane_t wr_en,
	output io_map_pkg::data_t rd_data,
	io_reg_if.host            irq_bus,
	io_reg_if.host            tmr_bus,
	io_reg_if.host            gpio_bus
);

	function automatic logic in_block(input io_map_pkg::addr_t a, input io_map_pkg::addr_t base);
		return (a >= base) && (32'(a) < 32'(base) + `IO_BLOCK_BYTES);
	endfunction

	function automatic io_map_pkg::reg_off_t block_off(input io_map_pkg::addr_t a,
		input io_map_pkg::addr_t base);
		io_map_pkg::addr_t d;
		d = a - base;
		return {d[2:1], 1'b0}; // Odd byte address ignored.
	endfunction

	logic              wr_any;
	logic              rd_hit;
	logic              same_word;
	io_map_pkg::data_t rd_word;
	io_map_pkg::data_t rd_next;

	assign wr_any = |wr_en;

	// ------------------------------------------------------------
	assign irq_bus.sel    = in_block(rd_addr, `IO_IRQ_BASE);
	assign irq_bus.rd_off = block_off(rd_addr, `IO_IRQ_BASE);
	assign irq_bus.wr     = wr_any && in_block(wr_addr, `IO_IRQ_BASE);
	assign irq_bus.wr_off = block_off(wr_addr, `IO_IRQ_BASE);
	assign irq_bus.lanes  = wr_en;
	assign irq_bus.wdata  = wr_data;

	assign tmr_bus.sel    = in_block(rd_addr, `IO_TIMER_BASE);
	assign tmr_bus.rd_off = block_off(rd_addr, `IO_TIMER_BASE);
	assign tmr_bus.wr     = wr_any && in_block(wr_addr, `IO_TIMER_BASE);
	assign tmr_bus.wr_off = block_off(wr_addr, `IO_TIMER_BASE);
	assign tmr_bus.lanes  = wr_en;
	assign tmr_bus.wdata  = wr_data;

	assign gpio_bus.sel    = in_block(rd_addr, `IO_GPIO_BASE);
	assign gpio_bus.rd_off = block_off(rd_addr, `IO_GPIO_BASE);
	assign gpio_bus.wr     = wr_any && in_block(wr_addr, `IO_GPIO_BASE);
	assign gpio_bus.wr_off = block_off(wr_addr, `IO_GPIO_BASE);
	assign gpio_bus.lanes  = wr_en;
	assign gpio_bus.wdata  = wr_data;

	// ------------------------------------------------------------
	assign rd_hit    = irq_bus.sel | tmr_bus.sel | gpio_bus.sel;
	assign rd_word   = irq_bus.rdata | tmr_bus.rdata | gpio_bus.rdata; // Idle blocks drive 0.
	assign same_word = (rd_addr[`IO_ADDR_W-1:1] == wr_addr[`IO_ADDR_W-1:1]);

	always_comb
	begin
		rd_next = '0;
		if (rd_hit)
			rd_next = io_map_pkg::lane_merge(rd_word, wr_data, same_word ? wr_en : 2'b00);
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			rd_data <= '0;
		else
			rd_data <= rd_next;
	end

endmodule

// ==== rtl/io_gpio.sv ====
`timescale 1ns/1ps

module io_gpio
(
	input  logic                    clk,
	input  logic                    rst_n,
	io_reg_if.dev                   bus,
	input  io_regs_pkg::port_byte_t pins_in,
	output io_regs_pkg::port_byte_t pins_out,
	output io_regs_pkg::port_byte_t pins_oe
);

	io_regs_pkg::port_byte_t dir;
	io_regs_pkg::port_byte_t out;
	io_regs_pkg::port_byte_t in_meta;
	io_regs_pkg::port_byte_t in_sync;
	logic                    dir_wr;
	logic                    out_wr;

	assign dir_wr = bus.wr && bus.lanes[0] && (bus.wr_off == io_map_pkg::OFF_GPIO_DIR);
	assign out_wr = bus.wr && bus.lanes[0] && (bus.wr_off == io_map_pkg::OFF_GPIO_OUT);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			dir     <= '0;
			out     <= '0;
			in_meta <= '0;
			in_sync <= '0;
		end
		else
		begin
			if (dir_wr)
				dir <= bus.wdata[7:0];
			if (out_wr)
				out <= bus.wdata[7:0];
			in_meta <= pins_in; // Two-flop synchronizer.
			in_sync <= in_meta;
		end
	end

	assign pins_oe  = dir;
	assign pins_out = out;

	always_comb
	begin
		bus.rdata = '0;
		if (bus.sel)
		begin
			case (bus.rd_off)
				io_map_pkg::OFF_GPIO_DIR: bus.rdata = {8'h00, dir};
				io_map_pkg::OFF_GPIO_OUT: bus.rdata = {8'h00, out};
				io_map_pkg::OFF_GPIO_IN:  bus.rdata = {8'h00, in_sync};
				default: ;
			endcase
		end
	end

endmodule

// ==== rtl/io_macros.svh ====
`ifndef IO_MACROS_SVH
`define IO_MACROS_SVH

// Bus widths.
`define IO_ADDR_W 16
`define IO_DATA_W 16

// Peripheral address map.
`define IO_IRQ_BASE    16'h0010
`define IO_TIMER_BASE  16'h0018
`define IO_GPIO_BASE   16'h0028
`define IO_BLOCK_BYTES 8

`define IO_NUM_IRQ 2

`endif

// ==== rtl/io_map_pkg.sv ====
`include "io_macros.svh"

package io_map_pkg;

	typedef logic [`IO_ADDR_W-1:0] addr_t;
	typedef logic [`IO_DATA_W-1:0] data_t;
	typedef logic [1:0]            lane_t;
	typedef logic [2:0]            reg_off_t;

	// ------------------------------------------------------------
	localparam reg_off_t OFF_IRQ_ENABLE  = 3'd0;
	localparam reg_off_t OFF_IRQ_PENDING = 3'd2;

	localparam reg_off_t OFF_TMR_CONFIG  = 3'd0;
	localparam reg_off_t OFF_TMR_COUNTER = 3'd2;
	localparam reg_off_t OFF_TMR_RELOAD  = 3'd4;
	localparam reg_off_t OFF_TMR_COMPARE = 3'd6;

	localparam reg_off_t OFF_GPIO_DIR    = 3'd0;
	localparam reg_off_t OFF_GPIO_OUT    = 3'd2;
	localparam reg_off_t OFF_GPIO_IN     = 3'd4;

	// Byte-lane merge of new data over an old word.
	function automatic data_t lane_merge(input data_t old_word, input data_t new_word,
		input lane_t lanes);
		data_t res;
		res = old_word;
		if (lanes[0])
			res[7:0] = new_word[7:0];
		if (lanes[1])
			res[15:8] = new_word[15:8];
		return res;
	endfunction

endpackage

// ==== rtl/io_reg_if.sv ====
`timescale 1ns/1ps

interface io_reg_if;

	logic                 sel;
	logic                 wr;
	io_map_pkg::reg_off_t wr_off;
	io_map_pkg::reg_off_t rd_off;
	io_map_pkg::lane_t    lanes;
	io_map_pkg::data_t    wdata;
	io_map_pkg::data_t    rdata;

	modport host
	(
		output sel,
		output wr,
		output wr_off,
		output rd_off,
		output lanes,
		output wdata,
		input  rdata
	);

	modport dev
	(
		input  sel,
		input  wr,
		input  wr_off,
		input  rd_off,
		input  lanes,
		input  wdata,
		output rdata
	);

endinterface

// ==== rtl/io_regs_pkg.sv ====
`include "io_macros.svh"

package io_regs_pkg;

	// Timer config byte, MSB first.
	typedef struct packed
	{
		logic [3:0] reserved; // Read back as written.
		logic [1:0] prescale;
		logic       one_shot;
		logic       enable;
	} timer_cfg_s;

	typedef union packed
	{
		logic [7:0] raw;
		timer_cfg_s fields;
	} timer_cfg_u;

	typedef logic [`IO_NUM_IRQ-1:0] irq_vec_t;

	typedef logic [7:0] port_byte_t;

endpackage

// ==== rtl/io_system.sv ====
`timescale 1ns/1ps
`include "io_macros.svh"

module io_system
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [`IO_ADDR_W-1:0] rd_addr,
	output logic [`IO_DATA_W-1:0] rd_data,
	input  logic [`IO_ADDR_W-1:0] wr_addr,
	input  logic [`IO_DATA_W-1:0] wr_data,
	input  logic [1:0]            wr_en,
	output logic                  irq,
	input  logic [7:0]            gpio_in,
	output logic [7:0]            gpio_out,
	output logic [7:0]            gpio_oe
);

	logic [`IO_NUM_IRQ-1:0] irq_src; // Bit 0 overflow, bit 1 compare.

	io_reg_if irq_bus ();
	io_reg_if tmr_bus ();
	io_reg_if gpio_bus ();

	io_decoder u_decoder
	(
		.clk      (clk),
		.rst_n    (rst_n),
		.rd_addr  (rd_addr),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.wr_en    (wr_en),
		.rd_data  (rd_data),
		.irq_bus  (irq_bus),
		.tmr_bus  (tmr_bus),
		.gpio_bus (gpio_bus)
	);

	irq_controller #(.NUM_IRQ(`IO_NUM_IRQ)) u_irq
	(
		.clk     (clk),
		.rst_n   (rst_n),
		.bus     (irq_bus),
		.sources (irq_src),
		.irq     (irq)
	);

	io_timer u_timer
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.bus         (tmr_bus),
		.overflow    (irq_src[0]),
		.compare_hit (irq_src[1])
	);

	io_gpio u_gpio
	(
		.clk      (clk),
		.rst_n    (rst_n),
		.bus      (gpio_bus),
		.pins_in  (gpio_in),
		.pins_out (gpio_out),
		.pins_oe  (gpio_oe)
	);

endmodule

// ==== rtl/io_timer.sv ====
`timescale 1ns/1ps

module io_timer
(
	input  logic  clk,
	input  logic  rst_n,
	io_reg_if.dev bus,
	output logic  overflow,
	output logic  compare_hit
);

	io_regs_pkg::timer_cfg_u cfg;
	io_map_pkg::data_t       counter;
	io_map_pkg::data_t       reload;
	io_map_pkg::data_t       compare;
	io_map_pkg::data_t       step_val;
	logic [2:0]              presc_cnt;
	logic [2:0]              presc_max;
	logic                    tick;
	logic                    wrap;
	logic                    cfg_wr;
	logic                    cnt_wr;
	logic                    rld_wr;
	logic                    cmp_wr;

	always_comb
	begin
		cfg_wr = bus.wr && bus.lanes[0] && (bus.wr_off == io_map_pkg::OFF_TMR_CONFIG);
		cnt_wr = bus.wr && (bus.wr_off == io_map_pkg::OFF_TMR_COUNTER);
		rld_wr = bus.wr && (bus.wr_off == io_map_pkg::OFF_TMR_RELOAD);
		cmp_wr = bus.wr && (bus.wr_off == io_map_pkg::OFF_TMR_COMPARE);
	end

	// ------------------------------------------------------------
	assign presc_max = (3'd1 << cfg.fields.prescale) - 3'd1; // 1, 2, 4 or 8 cycles.
	assign tick      = cfg.fields.enable && (presc_cnt == presc_max);
	assign wrap      = (counter == '1);
	assign step_val  = wrap ? reload : counter + 16'd1;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			cfg         <= '0;
			counter     <= '0;
			reload      <= '0;
			compare     <= '0;
			presc_cnt   <= '0;
			overflow    <= 1'b0;
			compare_hit <= 1'b0;
		end
		else
		begin
			overflow    <= 1'b0;
			compare_hit <= 1'b0;
			if (cnt_wr || tick || !cfg.fields.enable)
				presc_cnt <= '0;
			else
				presc_cnt <= presc_cnt + 3'd1;
			if (cnt_wr)
				counter <= io_map_pkg::lane_merge(counter, bus.wdata, bus.lanes);
			else if (tick)
			begin
				counter     <= step_val;
				overflow    <= wrap;
				compare_hit <= (step_val == compare);
				if (wrap && cfg.fields.one_shot)
					cfg.fields.enable <= 1'b0; // One-shot stops here.
			end
			if (cfg_wr)
				cfg.raw <= bus.wdata[7:0]; // Bus write beats one-shot stop.
			if (rld_wr)
				reload <= io_map_pkg::lane_merge(reload, bus.wdata, bus.lanes);
			if (cmp_wr)
				compare <= io_map_pkg::lane_merge(compare, bus.wdata, bus.lanes);
		end
	end

	always_comb
	begin
		bus.rdata = '0;
		if (bus.sel)
		begin
			case (bus.rd_off)
				io_map_pkg::OFF_TMR_CONFIG:  bus.rdata = {8'h00, cfg.raw};
				io_map_pkg::OFF_TMR_COUNTER: bus.rdata = counter;
				io_map_pkg::OFF_TMR_RELOAD:  bus.rdata = reload;
				io_map_pkg::OFF_TMR_COMPARE: bus.rdata = compare;
				default: ;
			endcase
		end
	end

endmodule

// ==== rtl/irq_controller.sv ====
`timescale 1ns/1ps

module irq_controller
#(
	parameter int NUM_IRQ = 2
)
(
	input  logic                  clk,
	input  logic                  rst_n,
	io_reg_if.dev                 bus,
	input  io_regs_pkg::irq_vec_t sources,
	output logic                  irq
);

	logic [NUM_IRQ-1:0] enable;
	logic [NUM_IRQ-1:0] pending;
	logic [NUM_IRQ-1:0] clr;
	logic               en_wr;
	logic               pend_wr;

	assign en_wr   = bus.wr && bus.lanes[0] && (bus.wr_off == io_map_pkg::OFF_IRQ_ENABLE);
	assign pend_wr = bus.wr && bus.lanes[0] && (bus.wr_off == io_map_pkg::OFF_IRQ_PENDING);
	assign clr     = pend_wr ? bus.wdata[NUM_IRQ-1:0] : '0; // Write 1 to clear.

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			enable  <= '0;
			pending <= '0;
			irq     <= 1'b0;
		end
		else
		begin
			if (en_wr)
				enable <= bus.wdata[NUM_IRQ-1:0];
			pending <= (pending & ~clr) | sources; // Set wins over clear.
			irq     <= |(pending & enable);
		end
	end

	always_comb
	begin
		bus.rdata = '0;
		if (bus.sel)
		begin
			case (bus.rd_off)
				io_map_pkg::OFF_IRQ_ENABLE:  bus.rdata[NUM_IRQ-1:0] = enable;
				io_map_pkg::OFF_IRQ_PENDING: bus.rdata[NUM_IRQ-1:0] = pending;
				default: ;
			endcase
		end
	end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build io_system_tb with Verilator, run it, and judge the log.
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"
verilator --binary --timing --assert --timescale 1ns/1ps -f files.f \
	--top-module io_system_tb -o io_system_sim > "$LOG" 2>&1 \
	&& ./obj_dir/io_system_sim >> "$LOG" 2>&1 \
	|| echo ">>> FAIL" >> "$LOG"
cat "$LOG"
grep -q ">>> FAIL" "$LOG" && exit 1 || exit 0

// ==== testbench/io_system_checker.sv ====
`timescale 1ns/1ps

module io_system_checker
(
	input logic       clk,
	input logic       rst_n,
	input logic       irq,
	input logic [7:0] gpio_oe,
	input logic [1:0] pending,
	input logic [1:0] enable
);

	irq_quiet_in_reset: assert property (@(posedge clk) !rst_n |=> !irq)
		else $error("irq high after a reset cycle");

	oe_clear_in_reset: assert property (@(posedge clk) !rst_n |=> (gpio_oe == 8'h00))
		else $error("gpio_oe driven after a reset cycle");

	// irq is registered, so it looks back one cycle.
	irq_needs_source: assert property (@(posedge clk) disable iff (!rst_n)
		irq |-> $past((pending & enable) != 2'b00))
		else $error("irq without an enabled pending bit");

endmodule

bind io_system io_system_checker u_checker
(
	.clk     (clk),
	.rst_n   (rst_n),
	.irq     (irq),
	.gpio_oe (gpio_oe),
	.pending (u_irq.pending),
	.enable  (u_irq.enable)
);

// ==== testbench/io_system_tb.sv ====
`timescale 1ns/1ps
`include "io_macros.svh"

module io_system_tb;

	localparam int N_PHASE       = 5;
	localparam int OPS_PER_PHASE = 400;
	localparam int N_OPS         = N_PHASE * OPS_PER_PHASE;
	localparam int CYCLE_LIMIT   = N_OPS * 4 + 200;

	logic        clk;
	logic        rst_n;
	logic [15:0] rd_addr;
	logic [15:0] rd_data;
	logic [15:0] wr_addr;
	logic [15:0] wr_data;
	logic [1:0]  wr_en;
	logic        irq;
	logic [7:0]  gpio_in;
	logic [7:0]  gpio_out;
	logic [7:0]  gpio_oe;

	logic [15:0] n_ra; // Next inputs.
	logic [15:0] n_wa;
	logic [15:0] n_wd;
	logic [1:0]  n_we;
	logic [7:0]  n_gin;

	// ------------------------------------------------------------
	logic [1:0]  m_en;
	logic [1:0]  m_pend;
	logic        m_irq;
	logic [7:0]  m_cfg;
	logic [15:0] m_cnt;
	logic [15:0] m_rld;
	logic [15:0] m_cmp;
	logic [15:0] m_rd;
	int          m_presc;
	logic        m_ovf;
	logic        m_hit;
	logic [7:0]  m_dir;
	logic [7:0]  m_out;
	logic [7:0]  m_meta;
	logic [7:0]  m_sync;
	logic        model_live = 1'b0;

	logic [31:0] lfsr;
	string       test_name;
	int          err_rd = 0;
	int          err_irq = 0;
	int          err_gpio = 0;
	int          cycle_cnt = 0;

	io_tb_clock u_clock (.clk(clk));

	io_system uut
	(
		.clk      (clk),
		.rst_n    (rst_n),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.wr_en    (wr_en),
		.irq      (irq),
		.gpio_in  (gpio_in),
		.gpio_out (gpio_out),
		.gpio_oe  (gpio_oe)
	);

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1.
	endfunction

	function automatic logic [31:0] draw_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [15:0] merge_lanes(input logic [15:0] old_v,
		input logic [15:0] new_v, input logic [1:0] lanes);
		return {lanes[1] ? new_v[15:8] : old_v[15:8], lanes[0] ? new_v[7:0] : old_v[7:0]};
	endfunction

	// Word offset inside a block, or -1 outside it.
	function automatic int block_off(input logic [15:0] a, input logic [15:0] base);
		int d;
		d = int'(a) - int'(base);
		if (d < 0 || d >= `IO_BLOCK_BYTES)
			return -1;
		return d & 6;
	endfunction

	function automatic logic is_mapped(input logic [15:0] a);
		return block_off(a, `IO_IRQ_BASE) >= 0 || block_off(a, `IO_TIMER_BASE) >= 0
			|| block_off(a, `IO_GPIO_BASE) >= 0;
	endfunction

	function automatic logic [15:0] reg_value(input logic [15:0] a);
		logic [15:0] v;
		v = 16'h0000;
		case (block_off(a, `IO_IRQ_BASE))
			0:       v = {14'd0, m_en};
			2:       v = {14'd0, m_pend};
			default: ;
		endcase
		case (block_off(a, `IO_TIMER_BASE))
			0:       v = {8'h00, m_cfg};
			2:       v = m_cnt;
			4:       v = m_rld;
			6:       v = m_cmp;
			default: ;
		endcase
		case (block_off(a, `IO_GPIO_BASE))
			0:       v = {8'h00, m_dir};
			2:       v = {8'h00, m_out};
			4:       v = {8'h00, m_sync};
			default: ;
		endcase
		return v;
	endfunction

	function automatic logic [15:0] pick_addr(input logic [1:0] region, input logic [15:0] raw);
		case (region)
			2'd0:    return 16'(`IO_IRQ_BASE) + (raw & 16'h0007);
			2'd1:    return 16'(`IO_TIMER_BASE) + (raw & 16'h0007);
			2'd2:    return 16'(`IO_GPIO_BASE) + (raw & 16'h0007);
			default: return raw & 16'h003F; // Mostly gaps around the blocks.
		endcase
	endfunction

	function automatic string phase_name(input int p);
		case (p)
			0:       return "readback";
			1:       return "forward_unmapped";
			2:       return "timer";
			3:       return "irq";
			default: return "gpio";
		endcase
	endfunction

	task automatic reset_model();
		m_en    = '0;
		m_pend  = '0;
		m_irq   = 1'b0;
		m_cfg   = '0;
		m_cnt   = '0;
		m_rld   = '0;
		m_cmp   = '0;
		m_rd    = '0;
		m_presc = 0;
		m_ovf   = 1'b0;
		m_hit   = 1'b0;
		m_dir   = '0;
		m_out   = '0;
		m_meta  = '0;
		m_sync  = '0;
	endtask

	// One clock edge of the reference model, from the inputs applied at this edge.
	task automatic advance_model();
		logic [15:0] rword;
		logic [15:0] nxt;
		logic [1:0]  clr;
		logic        wr;
		logic        tick;
		logic        cnt_wr;
		wr    = (wr_en != 2'b00);
		rword = reg_value(rd_addr);
		if (is_mapped(rd_addr) && rd_addr[15:1] == wr_addr[15:1])
			rword = merge_lanes(rword, wr_data, wr_en); // Same-word forwarding.
		m_rd  = rword;

		clr = 2'b00;
		if (wr && wr_en[0] && block_off(wr_addr, `IO_IRQ_BASE) == 2)
			clr = wr_data[1:0];
		m_irq  = (m_pend & m_en) != 2'b00;
		m_pend = (m_pend & ~clr) | {m_hit, m_ovf};
		if (wr && wr_en[0] && block_off(wr_addr, `IO_IRQ_BASE) == 0)
			m_en = wr_data[1:0];

		tick   = m_cfg[0] && (m_presc == (1 << m_cfg[3:2]) - 1);
		cnt_wr = wr && block_off(wr_addr, `IO_TIMER_BASE) == 2;
		m_ovf  = 1'b0;
		m_hit  = 1'b0;
		if (cnt_wr || tick || !m_cfg[0])
			m_presc = 0;
		else
			m_presc = (m_presc + 1) % 8; // Three-bit prescaler wraps.
		if (cnt_wr)
			m_cnt = merge_lanes(m_cnt, wr_data, wr_en);
		else if (tick)
		begin
			nxt   = (m_cnt == 16'hFFFF) ? m_rld : m_cnt + 16'd1;
			m_ovf = (m_cnt == 16'hFFFF);
			m_hit = (nxt == m_cmp);
			m_cnt = nxt;
			if (m_ovf && m_cfg[1])
				m_cfg[0] = 1'b0;
		end
		if (wr && wr_en[0] && block_off(wr_addr, `IO_TIMER_BASE) == 0)
			m_cfg = wr_data[7:0];
		if (wr && block_off(wr_addr, `IO_TIMER_BASE) == 4)
			m_rld = merge_lanes(m_rld, wr_data, wr_en);
		if (wr && block_off(wr_addr, `IO_TIMER_BASE) == 6)
			m_cmp = merge_lanes(m_cmp, wr_data, wr_en);

		if (wr && wr_en[0] && block_off(wr_addr, `IO_GPIO_BASE) == 0)
			m_dir = wr_data[7:0];
		if (wr && wr_en[0] && block_off(wr_addr, `IO_GPIO_BASE) == 2)
			m_out = wr_data[7:0];
		m_sync = m_meta;
		m_meta = gpio_in;
	endtask

	// ------------------------------------------------------------
	task automatic choose_op(input int phase);
		logic [4:0] sel;
		n_we  = 2'(draw_bits(2));
		n_wd  = 16'(draw_bits(16));
		n_gin = 8'(draw_bits(8));
		n_ra  = pick_addr(2'(draw_bits(2)), 16'(draw_bits(16)));
		n_wa  = pick_addr(2'(draw_bits(2)), 16'(draw_bits(16)));
		sel   = 5'(draw_bits(5));
		case (phase)
			0:
			begin
				case (sel[2:0])
					3'd0:    n_wa = 16'(`IO_GPIO_BASE);
					3'd1:    n_wa = 16'(`IO_GPIO_BASE) + 16'd2;
					3'd2:    n_wa = 16'(`IO_IRQ_BASE);
					3'd3:    n_wa = 16'(`IO_TIMER_BASE);
					3'd4:    n_wa = 16'(`IO_TIMER_BASE) + 16'd4;
					default: n_wa = 16'(`IO_TIMER_BASE) + 16'd6;
				endcase
				n_wa = n_wa | 16'(draw_bits(1)); // Odd byte address.
			end
			1:
				n_ra = {n_wa[15:1], 1'(draw_bits(1))};
			2, 3:
			begin
				n_ra = 16'(phase == 2 ? `IO_TIMER_BASE : `IO_IRQ_BASE)
					+ {14'd0, 1'(draw_bits(1)), 1'b0};
				if (sel < 5'd4)
				begin
					// Values near the top so the counter wraps often.
					n_wa = 16'(`IO_TIMER_BASE) + {13'd0, sel[1:0], 1'b0};
					n_wd = (sel == 5'd0) ? {8'h00, 7'(draw_bits(7)), 1'b1}
						: {12'hFFF, 4'(draw_bits(4))};
					n_we = 2'b11;
				end
				else if (phase == 3 && sel < 5'd6)
					n_wa = 16'(`IO_IRQ_BASE) + {13'd0, sel[1:0], 1'b0};
				else
					n_we = 2'b00;
			end
			default:
			begin
				n_ra = pick_addr(2'd2, 16'(draw_bits(16)));
				n_wa = 16'(`IO_GPIO_BASE) + (sel[0] ? 16'd2 : 16'd0);
			end
		endcase
	endtask

	always @(posedge clk)
	begin
		if (!rst_n)
			reset_model();
		else
			advance_model();
		model_live <= 1'b1;
	end

	always @(negedge clk)
	begin
		if (model_live)
		begin
			if (rd_data !== m_rd)
			begin
				err_rd = err_rd + 1;
				$display("ERROR %s: rd_data expected %h actual %h", test_name, m_rd, rd_data);
			end
			if (irq !== m_irq)
			begin
				err_irq = err_irq + 1;
				$display("ERROR %s: irq expected %b actual %b", test_name, m_irq, irq);
			end
			if (gpio_oe !== m_dir)
			begin
				err_gpio = err_gpio + 1;
				$display("ERROR %s: gpio_oe expected %h actual %h", test_name, m_dir, gpio_oe);
			end
			if (gpio_out !== m_out)
			begin
				err_gpio = err_gpio + 1;
				$display("ERROR %s: gpio_out expected %h actual %h", test_name, m_out, gpio_out);
			end
		end
	end

	initial
	begin
		while (cycle_cnt < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycle_cnt = cycle_cnt + 1;
		end
		$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display(">>> FAIL");
		$finish;
	end

	initial
	begin
		lfsr      = 32'h4259_6600;
		test_name = "reset";
		rst_n     = 1'b0;
		rd_addr   = 16'h0000;
		wr_addr   = 16'h0000;
		wr_data   = 16'h0000;
		wr_en     = 2'b00;
		gpio_in   = 8'h00;
		repeat (16)
			@(posedge clk);
		rst_n <= 1'b1;
		for (int p = 0; p < N_PHASE; p++)
		begin
			for (int k = 0; k < OPS_PER_PHASE; k++)
			begin
				@(posedge clk);
				test_name = phase_name(p);
				choose_op(p);
				rd_addr <= n_ra;
				wr_addr <= n_wa;
				wr_data <= n_wd;
				wr_en   <= n_we;
				gpio_in <= n_gin;
			end
		end
		@(posedge clk);
		wr_en <= 2'b00;
		repeat (4)
			@(posedge clk);
		$display("Errors: %0d total, rd_data %0d, irq %0d, gpio %0d, over %0d ops",
			err_rd + err_irq + err_gpio, err_rd, err_irq, err_gpio, N_OPS);
		if (err_rd + err_irq + err_gpio == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== testbench/io_tb_clock.sv ====
`timescale 1ns/1ps

module io_tb_clock
#(
	parameter real PERIOD_NS = 4.0
)
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD_NS / 2.0) clk = ~clk;
	end

endmodule
